/* src/CorePkg.sv */
package CorePkg;

    // --------------------------------------------------
    // Widths and basic types
    // --------------------------------------------------

    localparam int XLEN    = 32;  // Data path width
    localparam int NUM_GPR = 32;  // Integer register count

    typedef logic [XLEN-1:0]            Data;
    typedef logic [XLEN-1:0]            InstAddr;
    typedef logic [XLEN-1:0]            DataAddr;
    typedef logic [$clog2(NUM_GPR)-1:0] GPRAddr;
    typedef logic [31:0]                Inst;     // Always 32 bits in RV32I

    // --------------------------------------------------
    // Encodings
    // --------------------------------------------------

    typedef enum logic [6:0] {  // Major opcodes, integer subset
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_OPIMM  = 7'b0010011,
        OP_OP     = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111
    } Opcode;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_PASSB                              // Operand B straight through (LUI)
    } AluOp;

    typedef enum logic [3:0] {
        BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU,
        BR_JUMP,                               // JAL
        BR_JUMPREG                             // JALR, target from rs1
    } BrCond;

    typedef enum logic [1:0] {ACC_BYTE, ACC_HALF, ACC_WORD} DataAccess;
    typedef enum logic [1:0] {OPA_REG, OPA_PC, OPA_ZERO}    OperandASel;
    typedef enum logic [1:0] {OPB_REG, OPB_IMM, OPB_FOUR}   OperandBSel;
    typedef enum logic       {WR_ALU, WR_MEM}               WrDataSel;

    // --------------------------------------------------
    // Control and bus traffic
    // --------------------------------------------------

    typedef struct packed {
        AluOp       aluOp;
        OperandASel operandASel;
        OperandBSel operandBSel;
        BrCond      brCond;
        logic       regWrEnable;
        logic       memRdEnable;
        logic       memWrEnable;
        DataAccess  memAccess;
        logic       memUnsigned;  // Zero extend on load
        WrDataSel   wrDataSel;
    } CtrlSignals;

    typedef struct packed {
        InstAddr addr;
    } InstReq;

    typedef struct packed {
        DataAddr    addr;
        Data        wdata;
        logic [3:0] byteEn;  // One bit per byte lane
        logic       we;
        logic       re;
    } DataReq;

endpackage

/* src/FetchUnit.sv */
`timescale 1ns/10ps

module FetchUnit (
    input  logic             i_clock,
    input  logic             i_arstN,
    input  logic             i_brTaken,   // Branch or jump resolved taken
    input  CorePkg::BrCond   i_brCond,
    input  CorePkg::Data     i_imm,
    input  CorePkg::Data     i_rs1Data,   // JALR base
    output CorePkg::InstAddr o_pc,
    output CorePkg::InstReq  o_instReq);

    import CorePkg::*;

    InstAddr pc;
    InstAddr pcNext;
    Data     regTarget;  // rs1 + imm for JALR

    // Three-way next PC
    always_comb begin
        regTarget = i_rs1Data + i_imm;
        if (i_brTaken && i_brCond == BR_JUMPREG)
            pcNext = {regTarget[XLEN-1:1], 1'b0};  // Bit 0 cleared per spec
        else if (i_brTaken)
            pcNext = pc + i_imm;                   // PC relative
        else
            pcNext = pc + InstAddr'(4);
    end

    always_ff @(posedge i_clock or negedge i_arstN) begin
        if (!i_arstN)
            pc <= '0;  // Boot address
        else
            pc <= pcNext;
    end

    assign o_pc           = pc;
    assign o_instReq.addr = pc;

endmodule

/* src/InstDecoder.sv */
`timescale 1ns/10ps

module InstDecoder (
    input  CorePkg::Inst        i_inst,
    output CorePkg::GPRAddr     o_rs1,
    output CorePkg::GPRAddr     o_rs2,
    output CorePkg::GPRAddr     o_rd,
    output CorePkg::Data        o_imm,
    output CorePkg::CtrlSignals o_ctrl);

    import CorePkg::*;

    Opcode      opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    // ALU op from funct3, alt selects SUB / SRA
    function automatic AluOp aluFromFunct(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign opcode = Opcode'(i_inst[6:0]);
    assign funct3 = i_inst[14:12];
    assign funct7 = i_inst[31:25];
    assign o_rd   = i_inst[11:7];
    assign o_rs1  = i_inst[19:15];
    assign o_rs2  = i_inst[24:20];

    // --------------------------------------------------
    // Immediate and control
    // --------------------------------------------------

    always_comb begin
        o_ctrl = '0;  // Enables low, ADD, REG operands
        o_imm  = {{20{i_inst[31]}}, i_inst[31:20]};  // I-type by default
        case (opcode)
            OP_LUI, OP_AUIPC: begin
                o_imm                = {i_inst[31:12], 12'b0};
                o_ctrl.aluOp         = (opcode == OP_LUI) ? ALU_PASSB : ALU_ADD;
                o_ctrl.operandASel   = (opcode == OP_LUI) ? OPA_ZERO : OPA_PC;
                o_ctrl.operandBSel   = OPB_IMM;
                o_ctrl.regWrEnable   = 1'b1;
            end
            OP_JAL, OP_JALR: begin  // Link value pc + 4 from the ALU
                if (opcode == OP_JAL)
                    o_imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12],
                             i_inst[20], i_inst[30:21], 1'b0};
                o_ctrl.operandASel   = OPA_PC;
                o_ctrl.operandBSel   = OPB_FOUR;
                o_ctrl.brCond        = (opcode == OP_JAL) ? BR_JUMP : BR_JUMPREG;
                o_ctrl.regWrEnable   = 1'b1;
            end
            OP_BRANCH: begin
                o_imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7],
                         i_inst[30:25], i_inst[11:8], 1'b0};
                case (funct3)
                    3'b000:  o_ctrl.brCond = BR_EQ;
                    3'b001:  o_ctrl.brCond = BR_NE;
                    3'b100:  o_ctrl.brCond = BR_LT;
                    3'b101:  o_ctrl.brCond = BR_GE;
                    3'b110:  o_ctrl.brCond = BR_LTU;
                    3'b111:  o_ctrl.brCond = BR_GEU;
                    default: o_ctrl.brCond = BR_NONE;  // Reserved, never taken
                endcase
            end
            OP_LOAD, OP_STORE: begin
                if (opcode == OP_STORE)
                    o_imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
                o_ctrl.operandBSel   = OPB_IMM;  // Address = rs1 + imm
                o_ctrl.regWrEnable   = (opcode == OP_LOAD);
                o_ctrl.memRdEnable   = (opcode == OP_LOAD);
                o_ctrl.memWrEnable   = (opcode == OP_STORE);
                o_ctrl.memUnsigned   = funct3[2];
                o_ctrl.wrDataSel     = WR_MEM;
                case (funct3[1:0])
                    2'b00:   o_ctrl.memAccess = ACC_BYTE;
                    2'b01:   o_ctrl.memAccess = ACC_HALF;
                    default: o_ctrl.memAccess = ACC_WORD;
                endcase
            end
            OP_OPIMM: begin  // Only SRAI uses funct7
                o_ctrl.aluOp         = aluFromFunct(funct3, funct3 == 3'b101 && funct7[5]);
                o_ctrl.operandBSel   = OPB_IMM;
                o_ctrl.regWrEnable   = 1'b1;
            end
            OP_OP: begin
                o_ctrl.aluOp         = aluFromFunct(funct3, funct7[5]);
                o_ctrl.regWrEnable   = 1'b1;
            end
            default: ;  // Unknown opcode, no-op
        endcase
    end

endmodule

/* src/GPRegisters.sv */
`timescale 1ns/10ps

module GPRegisters (
    input  logic            i_clock,
    input  logic            i_arstN,
    input  CorePkg::GPRAddr i_raddrA,
    input  CorePkg::GPRAddr i_raddrB,
    input  CorePkg::GPRAddr i_waddr,
    input  logic            i_we,
    input  CorePkg::Data    i_wdata,
    output CorePkg::Data    o_rdataA,
    output CorePkg::Data    o_rdataB);

    import CorePkg::*;

    Data regs [1:NUM_GPR-1];  // x0 has no storage

    always_ff @(posedge i_clock or negedge i_arstN) begin
        if (!i_arstN) begin
            for (int i = 1; i < NUM_GPR; i++)
                regs[i] <= '0;
        end else if (i_we && i_waddr != '0) begin
            regs[i_waddr] <= i_wdata;  // Writes to x0 dropped
        end
    end

    // Asynchronous read, x0 hardwired to zero
    assign o_rdataA = (i_raddrA == '0) ? '0 : regs[i_raddrA];
    assign o_rdataB = (i_raddrB == '0) ? '0 : regs[i_raddrB];

endmodule

/* src/ExecuteUnit.sv */
`timescale 1ns/10ps

module ExecuteUnit (
    input  CorePkg::CtrlSignals i_ctrl,
    input  CorePkg::InstAddr    i_pc,
    input  CorePkg::Data        i_rs1Data,
    input  CorePkg::Data        i_rs2Data,
    input  CorePkg::Data        i_imm,
    output CorePkg::Data        o_aluResult,
    output logic                o_brTaken);

    import CorePkg::*;

    Data        opA;
    Data        opB;
    logic [4:0] shamt;       // Low five bits of operand B
    logic       isEqual;
    logic       isLessSigned;
    logic       isLessUnsigned;

    // --------------------------------------------------
    // Operand selection and ALU
    // --------------------------------------------------

    always_comb begin
        case (i_ctrl.operandASel)
            OPA_PC:   opA = Data'(i_pc);
            OPA_ZERO: opA = '0;
            default:  opA = i_rs1Data;
        endcase
        case (i_ctrl.operandBSel)
            OPB_IMM:  opB = i_imm;
            OPB_FOUR: opB = Data'(4);  // Link offset
            default:  opB = i_rs2Data;
        endcase
    end

    assign shamt = opB[4:0];

    always_comb begin
        case (i_ctrl.aluOp)
            ALU_SUB:   o_aluResult = opA - opB;
            ALU_SLL:   o_aluResult = opA << shamt;
            ALU_SLT:   o_aluResult = Data'($signed(opA) < $signed(opB));
            ALU_SLTU:  o_aluResult = Data'(opA < opB);
            ALU_XOR:   o_aluResult = opA ^ opB;
            ALU_SRL:   o_aluResult = opA >> shamt;
            ALU_SRA:   o_aluResult = Data'($signed(opA) >>> shamt);  // Sign fill
            ALU_OR:    o_aluResult = opA | opB;
            ALU_AND:   o_aluResult = opA & opB;
            ALU_PASSB: o_aluResult = opB;
            default:   o_aluResult = opA + opB;
        endcase
    end

    // --------------------------------------------------
    // Branch comparison
    // --------------------------------------------------

    assign isEqual        = (i_rs1Data == i_rs2Data);
    assign isLessSigned   = ($signed(i_rs1Data) < $signed(i_rs2Data));
    assign isLessUnsigned = (i_rs1Data < i_rs2Data);

    always_comb begin
        case (i_ctrl.brCond)
            BR_EQ:              o_brTaken = isEqual;
            BR_NE:              o_brTaken = !isEqual;
            BR_LT:              o_brTaken = isLessSigned;
            BR_GE:              o_brTaken = !isLessSigned;
            BR_LTU:             o_brTaken = isLessUnsigned;
            BR_GEU:             o_brTaken = !isLessUnsigned;
            BR_JUMP, BR_JUMPREG: o_brTaken = 1'b1;  // Unconditional
            default:            o_brTaken = 1'b0;
        endcase
    end

endmodule

/* src/MemAccess.sv */
`timescale 1ns/10ps

module MemAccess (
    input  logic                i_arstN,
    input  CorePkg::CtrlSignals i_ctrl,
    input  CorePkg::Data        i_aluResult,   // Effective address or result
    input  CorePkg::Data        i_rs2Data,     // Store data
    input  CorePkg::Data        i_dataRdata,
    output CorePkg::DataReq     o_dataReq,
    output CorePkg::Data        o_wrData,
    output logic                o_regWe);

    import CorePkg::*;

    logic [1:0] byteOfs;   // Lane of the access
    Data        shifted;   // Read word moved down to lane 0
    Data        loadData;

    assign byteOfs = i_aluResult[1:0];

    // --------------------------------------------------
    // Store side
    // --------------------------------------------------

    always_comb begin
        o_dataReq.addr = DataAddr'(i_aluResult);
        o_dataReq.we   = i_ctrl.memWrEnable & i_arstN;  // Quiet bus in reset
        o_dataReq.re   = i_ctrl.memRdEnable & i_arstN;
        case (i_ctrl.memAccess)
            ACC_BYTE: begin
                o_dataReq.wdata  = {4{i_rs2Data[7:0]}};
                o_dataReq.byteEn = 4'b0001 << byteOfs;
            end
            ACC_HALF: begin
                o_dataReq.wdata  = {2{i_rs2Data[15:0]}};
                o_dataReq.byteEn = byteOfs[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                o_dataReq.wdata  = i_rs2Data;
                o_dataReq.byteEn = 4'b1111;
            end
        endcase
    end

    // --------------------------------------------------
    // Load extension and write-back
    // --------------------------------------------------

    assign shifted = i_dataRdata >> {byteOfs, 3'b000};

    always_comb begin
        case (i_ctrl.memAccess)
            ACC_BYTE: loadData = i_ctrl.memUnsigned ? {24'b0, shifted[7:0]}
                                                    : {{24{shifted[7]}}, shifted[7:0]};
            ACC_HALF: loadData = i_ctrl.memUnsigned ? {16'b0, shifted[15:0]}
                                                    : {{16{shifted[15]}}, shifted[15:0]};
            default:  loadData = i_dataRdata;
        endcase
    end

    assign o_wrData = (i_ctrl.wrDataSel == WR_MEM) ? loadData : i_aluResult;
    assign o_regWe  = i_ctrl.regWrEnable & i_arstN;

endmodule

/* src/CoreSC.sv */
`timescale 1ns/10ps

module CoreSC (
    input  logic            i_clock,
    input  logic            i_arstN,
    output CorePkg::InstReq o_instReq,
    input  CorePkg::Inst    i_inst,       // Same cycle as o_instReq
    output CorePkg::DataReq o_dataReq,
    input  CorePkg::Data    i_dataRdata); // Same cycle as o_dataReq

    import CorePkg::*;

    InstAddr    pc;
    GPRAddr     rs1, rs2, rd;
    Data        imm;
    CtrlSignals ctrl;
    Data        rs1Data, rs2Data;
    Data        aluResult;
    logic       brTaken;
    Data        wrData;    // Write-back value
    logic       regWe;

    // --------------------------------------------------
    // Input side
    // --------------------------------------------------

    FetchUnit fetch (
        .i_clock   (i_clock),
        .i_arstN   (i_arstN),
        .i_brTaken (brTaken),
        .i_brCond  (ctrl.brCond),
        .i_imm     (imm),
        .i_rs1Data (rs1Data),
        .o_pc      (pc),
        .o_instReq (o_instReq));

    // --------------------------------------------------
    // Processing
    // --------------------------------------------------

    InstDecoder dec (
        .i_inst (i_inst),
        .o_rs1  (rs1),
        .o_rs2  (rs2),
        .o_rd   (rd),
        .o_imm  (imm),
        .o_ctrl (ctrl));

    GPRegisters gpr (
        .i_clock  (i_clock),
        .i_arstN  (i_arstN),
        .i_raddrA (rs1),
        .i_raddrB (rs2),
        .i_waddr  (rd),
        .i_we     (regWe),
        .i_wdata  (wrData),
        .o_rdataA (rs1Data),
        .o_rdataB (rs2Data));

    ExecuteUnit exec (
        .i_ctrl      (ctrl),
        .i_pc        (pc),
        .i_rs1Data   (rs1Data),
        .i_rs2Data   (rs2Data),
        .i_imm       (imm),
        .o_aluResult (aluResult),
        .o_brTaken   (brTaken));

    // Output side
    MemAccess mem (
        .i_arstN     (i_arstN),
        .i_ctrl      (ctrl),
        .i_aluResult (aluResult),
        .i_rs2Data   (rs2Data),
        .i_dataRdata (i_dataRdata),
        .o_dataReq   (o_dataReq),
        .o_wrData    (wrData),
        .o_regWe     (regWe));

endmodule

/* sim/CoreSC_chk.sv */
`timescale 1ns/10ps

module CoreSC_chk (
    input logic                i_clock,
    input logic                i_arstN,
    input CorePkg::InstAddr    i_pc,
    input CorePkg::InstReq     i_instReq,
    input CorePkg::DataReq     i_dataReq,
    input CorePkg::DataAccess  i_access);  // Size of the current access

    import CorePkg::*;

    int failCount = 0;  // Read by the testbench at the end

    // --------------------------------------------------
    // Reset behaviour
    // --------------------------------------------------

    pcInReset: assert property (@(posedge i_clock) !i_arstN |=> i_pc == '0)
        else begin
            $error("PC not held at zero during reset");
            failCount++;
        end

    quietBus: assert property (@(posedge i_clock)
        !i_arstN |-> !i_dataReq.we && !i_dataReq.re)
        else begin
            $error("Data bus active during reset");
            failCount++;
        end

    // --------------------------------------------------
    // Bus shape
    // --------------------------------------------------

    fetchAligned: assert property (@(posedge i_clock) disable iff (!i_arstN)
        i_instReq.addr[1:0] == 2'b00)
        else begin
            $error("Instruction fetch address not word aligned");
            failCount++;
        end

    laneByte: assert property (@(posedge i_clock) disable iff (!i_arstN)
        i_dataReq.we && i_access == ACC_BYTE |-> $onehot(i_dataReq.byteEn))
        else begin
            $error("Byte store without exactly one lane enabled");
            failCount++;
        end

    laneHalf: assert property (@(posedge i_clock) disable iff (!i_arstN)
        i_dataReq.we && i_access == ACC_HALF |-> i_dataReq.byteEn inside {4'b0011, 4'b1100})
        else begin
            $error("Half store lanes not an aligned pair");
            failCount++;
        end

    laneWord: assert property (@(posedge i_clock) disable iff (!i_arstN)
        i_dataReq.we && i_access == ACC_WORD |-> i_dataReq.byteEn == 4'b1111)
        else begin
            $error("Word store without all four lanes");
            failCount++;
        end

endmodule

bind CoreSC CoreSC_chk chk (
    .i_clock   (i_clock),
    .i_arstN   (i_arstN),
    .i_pc      (pc),
    .i_instReq (o_instReq),
    .i_dataReq (o_dataReq),
    .i_access  (ctrl.memAccess));

/* sim/CoreSC_tb.sv */
`timescale 1ns/10ps

module CoreSC_tb;

    import CorePkg::*;

    typedef struct packed {
        Data        value;
        logic [2:0] test;   // Index into testName
    } Expected;

    logic        clock = 1'b0;
    logic        arstN = 1'b0;
    InstReq      instReq;
    Inst         inst;
    DataReq      dataReq;
    Data         dataRdata;

    Inst         imem [0:1023];
    Data         dmem [0:255];       // Written per byte lane
    Expected     expQ [$];
    logic [15:0] lfsr = 16'd62;
    logic [11:0] resAddr = 12'h100;  // Next free result slot
    int          progLen = 0;        // In instructions
    int          cycles = 0;
    int          limit = 0;
    logic        done = 1'b0;        // End marker store seen
    int          otherErrors = 0;
    int          testsPassed = 0;
    int          testsFailed = 0;
    int          remaining [5] = '{default: 0};
    int          wrongCount [5] = '{default: 0};
    string       testName [5] = '{"ALU", "branch", "jump and upper immediate",
                                  "sub-word access", "register x0"};

    CoreSC uut (
        .i_clock     (clock),
        .i_arstN     (arstN),
        .o_instReq   (instReq),
        .i_inst      (inst),
        .o_dataReq   (dataReq),
        .i_dataRdata (dataRdata));

    initial begin
        forever #5 clock = ~clock;  // 10 ns period
    end

    // --------------------------------------------------
    // Memories
    // --------------------------------------------------

    assign inst      = imem[instReq.addr[11:2]];  // Combinational fetch
    assign dataRdata = dataReq.re ? dmem[dataReq.addr[9:2]] : '0;  // Only on a load request

    always @(posedge clock) begin
        if (dataReq.we) begin
            for (int i = 0; i < 4; i++)
                if (dataReq.byteEn[i])
                    dmem[dataReq.addr[9:2]][8*i +: 8] <= dataReq.wdata[8*i +: 8];
        end
    end

    // --------------------------------------------------
    // Encoders and reference rules
    // --------------------------------------------------

    function automatic Inst encR(input logic [6:0] f7, input logic [4:0] rs2,
                                 input logic [4:0] rs1, input logic [2:0] f3,
                                 input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_OP};
    endfunction

    function automatic Inst encI(input logic [11:0] imm, input logic [4:0] rs1,
                                 input logic [2:0] f3, input logic [4:0] rd, input Opcode op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic Inst encS(input logic [11:0] imm, input logic [4:0] rs2,
                                 input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic Inst encB(input logic [12:0] imm, input logic [4:0] rs2,
                                 input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic Inst encU(input logic [19:0] imm, input logic [4:0] rd, input Opcode op);
        return {imm, rd, op};
    endfunction

    function automatic Inst encJ(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    // Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic Data randBits(input int n);
        Data  r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic logic lessSigned(input Data a, input Data b);
        return (a[31] != b[31]) ? a[31] : (a < b);  // Sign decides first
    endfunction

    function automatic Data aluRef(input logic [2:0] f3, input logic alt, input Data a,
                                   input Data b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'b0, lessSigned(a, b)};
            3'd3:    return {31'b0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return (a >> b[4:0]) | ({32{alt & a[31]}} & ~(32'hFFFFFFFF >> b[4:0]));
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic brRef(input logic [2:0] f3, input Data a, input Data b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return lessSigned(a, b);
            3'd5:    return !lessSigned(a, b);
            3'd6:    return a < b;
            default: return !(a < b);
        endcase
    endfunction

    // --------------------------------------------------
    // Program assembly
    // --------------------------------------------------

    task automatic emit(input Inst word);
        imem[progLen] = word;
        progLen++;
    endtask

    task automatic loadReg(input logic [4:0] rd, input Data value);
        Data upper;
        upper = value + 32'h800;  // Compensates the signed ADDI part
        emit(encU(upper[31:12], rd, OP_LUI));
        emit(encI(value[11:0], rd, 3'b000, rd, OP_OPIMM));
    endtask

    task automatic storeResult(input logic [4:0] rs, input Data want, input logic [2:0] test);
        emit(encS(resAddr, rs, 5'd0, 3'b010));
        resAddr = resAddr + 12'd4;
        expQ.push_back('{value: want, test: test});
        remaining[test]++;
    endtask

    task automatic reportTest(input logic [2:0] t);
        if (wrongCount[t] == 0) begin
            testsPassed++;
            $display("%s test: ok", testName[t]);
        end else begin
            testsFailed++;
            $display("%s test: %0d wrong results", testName[t], wrongCount[t]);
        end
    endtask

    // --------------------------------------------------
    // Store monitor
    // --------------------------------------------------

    always @(posedge clock) begin : storeCheck
        Expected e;
        if (arstN && dataReq.we) begin
            assert (dataReq.wdata != 32'hDEADBEEF)
                else begin
                    $display("Poison value stored at %0t, a branch or jump missed", $time);
                    otherErrors++;
                end
            if (dataReq.addr == 32'h3FC) begin
                done = 1'b1;  // End of program
            end else if (dataReq.addr >= 32'h100) begin
                if (expQ.size() == 0) begin
                    $display("Store to %h at %0t with no result expected", dataReq.addr, $time);
                    otherErrors++;
                end else begin
                    e = expQ.pop_front();
                    assert (dataReq.wdata == e.value)
                        else begin
                            $display("MISMATCH at %0t: %s result at %h is %h, expected %h",
                                     $time, testName[e.test], dataReq.addr, dataReq.wdata,
                                     e.value);
                            wrongCount[e.test]++;
                        end
                    remaining[e.test]--;
                    if (remaining[e.test] == 0)
                        reportTest(e.test);
                end
            end
        end
    end

    always @(posedge clock) begin
        if (arstN)
            cycles <= cycles + 1;
    end

    initial begin
        Data        a;
        Data        b;
        Data        w;
        Data        hb;
        Data        imm;
        logic [2:0] f3;
        logic       alt;
        logic [7:0] bt;
        logic [15:0] hw;
        int         k;

        // First word is a store, held off the bus while in reset
        emit(encS(12'h080, 5'd0, 5'd0, 3'b010));

        // ALU, register and immediate forms
        for (int r = 0; r < 2; r++) begin
            a = randBits(32);
            b = randBits(32);
            loadReg(5'd1, a);
            loadReg(5'd2, b);
            for (int op = 0; op < 10; op++) begin  // SUB and SRA last
                f3  = (op < 8) ? 3'(op) : ((op == 8) ? 3'd0 : 3'd5);
                alt = (op >= 8);
                emit(encR(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, 5'd3));
                storeResult(5'd3, aluRef(f3, alt, a, b), 3'd0);
            end
            for (int op = 0; op < 9; op++) begin   // SRAI last
                f3  = (op < 8) ? 3'(op) : 3'd5;
                alt = (op == 8);
                imm = randBits(12);
                if (f3 == 3'd1 || f3 == 3'd5)
                    imm = {21'b0, alt, 5'b0, imm[4:0]};  // funct7 plus shamt
                else
                    imm = {{20{imm[11]}}, imm[11:0]};
                emit(encI(imm[11:0], 5'd1, f3, 5'd3, OP_OPIMM));
                storeResult(5'd3, aluRef(f3, alt, a, imm), 3'd0);
            end
        end

        // Branches, both paths jump over the poison store
        loadReg(5'd7, 32'hDEADBEEF);
        for (int c = 0; c < 6; c++) begin
            for (int p = 0; p < 2; p++) begin
                f3 = (c < 2) ? 3'(c) : 3'(c + 2);
                k  = c * 2 + p;
                a  = randBits(32);
                b  = (p == 1) ? a : randBits(32);  // Second pair equal
                loadReg(5'd1, a);
                loadReg(5'd2, b);
                emit(encI(12'(12'h400 + k), 5'd0, 3'b000, 5'd6, OP_OPIMM));
                emit(encB(13'd16, 5'd2, 5'd1, f3));
                emit(encI(12'(12'h200 + k), 5'd0, 3'b000, 5'd6, OP_OPIMM));
                emit(encJ(21'd8, 5'd0));
                emit(encS(resAddr, 5'd7, 5'd0, 3'b010));
                storeResult(5'd6, brRef(f3, a, b) ? Data'(32'h400 + k) : Data'(32'h200 + k),
                            3'd1);
            end
        end

        // Jumps and upper immediates
        k = progLen * 4;
        emit(encJ(21'd8, 5'd8));
        emit(encS(resAddr, 5'd7, 5'd0, 3'b010));
        storeResult(5'd8, Data'(k + 4), 3'd2);
        k = progLen * 4 + 8;                   // JALR follows the base load
        loadReg(5'd9, Data'(k));
        emit(encI(12'd9, 5'd9, 3'b000, 5'd10, OP_JALR));  // Odd target, bit 0 dropped
        emit(encS(resAddr, 5'd7, 5'd0, 3'b010));
        storeResult(5'd10, Data'(k + 4), 3'd2);
        w = randBits(20);
        emit(encU(w[19:0], 5'd11, OP_LUI));
        storeResult(5'd11, {w[19:0], 12'b0}, 3'd2);
        k = progLen * 4;
        w = randBits(20);
        emit(encU(w[19:0], 5'd12, OP_AUIPC));
        storeResult(5'd12, Data'(k) + {w[19:0], 12'b0}, 3'd2);

        // Sub-word loads from a known word at 0x80
        w = randBits(32);
        loadReg(5'd13, w);
        emit(encS(12'h080, 5'd13, 5'd0, 3'b010));
        for (int ofs = 0; ofs < 4; ofs++) begin
            bt = w[8*ofs +: 8];
            emit(encI(12'(12'h080 + ofs), 5'd0, 3'b000, 5'd14, OP_LOAD));
            storeResult(5'd14, {{24{bt[7]}}, bt}, 3'd3);
            emit(encI(12'(12'h080 + ofs), 5'd0, 3'b100, 5'd14, OP_LOAD));
            storeResult(5'd14, {24'b0, bt}, 3'd3);
            if (ofs % 2 == 0) begin
                hw = w[8*ofs +: 16];
                emit(encI(12'(12'h080 + ofs), 5'd0, 3'b001, 5'd14, OP_LOAD));
                storeResult(5'd14, {{16{hw[15]}}, hw}, 3'd3);
                emit(encI(12'(12'h080 + ofs), 5'd0, 3'b101, 5'd14, OP_LOAD));
                storeResult(5'd14, {16'b0, hw}, 3'd3);
            end
        end
        hb = randBits(32);                     // SB at lane 1, SH at lanes 2..3
        loadReg(5'd15, hb);
        emit(encS(12'h081, 5'd15, 5'd0, 3'b000));
        emit(encS(12'h082, 5'd15, 5'd0, 3'b001));
        emit(encI(12'h080, 5'd0, 3'b010, 5'd16, OP_LOAD));
        storeResult(5'd16, {hb[15:0], hb[7:0], w[7:0]}, 3'd3);

        // x0 stays zero
        emit(encI(12'h055, 5'd0, 3'b000, 5'd0, OP_OPIMM));
        storeResult(5'd0, 32'h0, 3'd4);
        emit(encS(12'h3FC, 5'd0, 5'd0, 3'b010));  // End marker
        limit = 2 * progLen + 50;

        repeat (3) @(posedge clock);
        @(negedge clock);
        arstN = 1'b1;
        while (!done && cycles < limit)
            @(negedge clock);

        if (!done) begin
            $display("Timeout: the program never finished within %0d cycles", limit);
            otherErrors++;
        end else if (expQ.size() != 0) begin
            $display("Program ended with %0d results never stored", expQ.size());
            otherErrors++;
        end
        otherErrors += uut.chk.failCount;      // Bound assertion failures
        $display("Tests: %0d passed, %0d failed", testsPassed, testsFailed);
        if (testsFailed == 0 && otherErrors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* CoreSC.f */
src/CorePkg.sv
src/FetchUnit.sv
src/InstDecoder.sv
src/GPRegisters.sv
src/ExecuteUnit.sv
src/MemAccess.sv
src/CoreSC.sv
sim/CoreSC_chk.sv
sim/CoreSC_tb.sv

/* Bender.yml */
package:
  name: core_sc

sources:
  - src/CorePkg.sv
  - src/FetchUnit.sv
  - src/InstDecoder.sv
  - src/GPRegisters.sv
  - src/ExecuteUnit.sv
  - src/MemAccess.sv
  - src/CoreSC.sv
  - target: test
    files:
      - sim/CoreSC_chk.sv
      - sim/CoreSC_tb.sv
